// File: Bender.yml
package:
  name: zx_pager

sources:
  - zx_pkg.sv
  - zx_port_decode.sv
  - zx_paging_regs.sv
  - zx_mem_map.sv
  - zx_pager_top.sv
  - target: test
    files:
      - tb_zx_pager_sva.sv
      - tb_zx_pager.sv

// File: compile.f
zx_pkg.sv
zx_port_decode.sv
zx_paging_regs.sv
zx_mem_map.sv
zx_pager_top.sv
tb_zx_pager_sva.sv
tb_zx_pager.sv

// File: tb_zx_pager.sv
// Directed testbench for the ZX Spectrum memory pager
// Expected values come from a small register model kept here
// Inputs change 2 ns after the rising edge, outputs are checked mid-cycle
// First mismatch stops the run

`timescale 1ns/1ps

module tb_zx_pager
	import zx_pkg::*;
();

	// Resets, port writes and map sweeps, each at its cycle cost
	localparam int TEST_CYCLES = 10 * 17 + 35 * 5 + 35 * 10;
	localparam int WATCHDOG_NS = TEST_CYCLES * 20 + 2000;

	logic                  clk_sys;
	logic                  reset;
	logic                  io_wr;
	logic [ADDR_W-1:0]     addr;
	logic [DATA_W-1:0]     data;
	logic                  mem_wr;
	mem_mode_e             mode_cfg;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_we;
	logic [3:0]            rom_page;
	logic [2:0]            border;
	logic                  ear;
	logic                  mic;
	logic                  scr_page;
	logic                  motor;

	// Register model
	mem_mode_e  m_mode;
	logic [7:0] m_7ffd;
	logic [7:0] m_1ffd;
	logic [2:0] m_ext;
	logic [2:0] m_border;
	logic       m_ear;
	logic       m_mic;
	integer     seed = 79;

	zx_pager_top u_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_wr_i    (io_wr),
		.addr_i     (addr),
		.data_i     (data),
		.mem_wr_i   (mem_wr),
		.mode_cfg_i (mode_cfg),
		.ram_addr_o (ram_addr),
		.ram_we_o   (ram_we),
		.rom_page_o (rom_page),
		.border_o   (border),
		.ear_o      (ear),
		.mic_o      (mic),
		.scr_page_o (scr_page),
		.motor_o    (motor)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ====================
	// Expected values
	// ====================
	function automatic logic [3:0] exp_rom_page();
		if (m_mode == MEM_48K) return 4'd15;
		if (m_mode == MEM_PLUS3) return 4'd8 + {m_1ffd[2], 1'b0} + m_7ffd[4];
		return 4'd6 + m_7ffd[4];
	endfunction

	function automatic logic in_special();
		return (m_mode == MEM_PLUS3) && m_1ffd[0];
	endfunction

	function automatic logic [6:0] exp_bank(input logic [1:0] q);
		logic [6:0] bank;
		if (in_special()) begin
			case (m_1ffd[2:1])
				2'd0:    bank = 7'(q);
				2'd1:    bank = 7'd4 + q;
				2'd2:    bank = (q == 2'd3) ? 7'd3 : 7'd4 + q;
				default: bank = (q == 2'd1) ? 7'd7 : ((q == 2'd3) ? 7'd3 : 7'd4 + q);
			endcase
		end else begin
			case (q)
				2'd0:    bank = {3'b101, exp_rom_page()};
				2'd1:    bank = 7'd5;
				2'd2:    bank = 7'd2;
				default: bank = {1'b0, m_ext, m_7ffd[2:0]};
			endcase
		end
		return bank;
	endfunction

	function automatic logic [15:0] addr_7ffd();
		logic [15:0] a;
		a = 16'($random(seed));
		a[15] = 1'b0;
		a[14] = 1'b1; // Needed on +3
		a[1] = 1'b0;
		a[0] = 1'b1;
		return a;
	endfunction

	function automatic logic [15:0] addr_1ffd();
		logic [15:0] a;
		a = 16'($random(seed));
		a[15:12] = 4'b0001;
		a[1] = 1'b0;
		a[0] = 1'b1;
		return a;
	endfunction

	// ====================
	// Drive and check
	// ====================
	task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
		assert (act === exp) else begin
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic drive_slot();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic reset_dut(input mem_mode_e mode);
		drive_slot();
		mode_cfg = mode;
		reset = 1'b1;
		io_wr = 1'b0;
		mem_wr = 1'b0;
		repeat (16) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		m_mode = mode;
		m_7ffd = '0;
		m_1ffd = '0;
		m_ext = '0;
		m_border = '0;
		m_ear = 1'b0;
		m_mic = 1'b0;
	endtask

	task automatic port_write(input logic [15:0] a, input logic [7:0] d);
		drive_slot();
		addr = a;
		data = d;
		io_wr = 1'b1;
		@(posedge clk_sys);
		#2;
		data = ~d; // Only the first edge of the strobe may take the byte
		repeat (2) @(posedge clk_sys); // Outputs settle after the second edge
		#2;
		io_wr = 1'b0;
	endtask

	task automatic check_map(input logic [1:0] q, input logic wr);
		logic [15:0] a;
		a = 16'($random(seed));
		a[15:14] = q;
		drive_slot();
		addr = a;
		mem_wr = wr;
		@(negedge clk_sys);
		check_val("ram_addr_o", ram_addr, {3'b000, exp_bank(q), a[13:0]});
		check_val("ram_we_o", ram_we, wr & (in_special() | (q != 2'd0)));
	endtask

	task automatic check_all();
		check_val("rom_page_o", rom_page, exp_rom_page());
		check_val("scr_page_o", scr_page, m_7ffd[3]);
		check_val("motor_o", motor, m_1ffd[3]);
		check_val("border_o", border, m_border);
		check_val("ear_o", ear, m_ear);
		check_val("mic_o", mic, m_mic);
		for (int q = 0; q < 4; q++) begin
			check_map(2'(q), 1'b0);
			check_map(2'(q), 1'b1);
		end
		drive_slot();
		mem_wr = 1'b0;
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_reset_128k();
		reset_dut(MEM_128K);
		check_val("rom_page_o", rom_page, 4'd6);
		check_all();
	endtask

	task automatic test_7ffd_lock();
		logic [7:0] d;
		reset_dut(MEM_128K);
		repeat (4) begin
			d = 8'($random(seed));
			d[5] = 1'b0;
			port_write(addr_7ffd(), d);
			m_7ffd = d;
			check_all();
		end
		d = 8'($random(seed));
		d[5] = 1'b1; // Lock until reset
		port_write(addr_7ffd(), d);
		m_7ffd = d;
		check_all();
		repeat (3) begin
			port_write(addr_7ffd(), 8'($random(seed)));
			check_all();
		end
		reset_dut(MEM_128K);
		check_all();
		port_write(16'h7FFD, 8'h1E);
		m_7ffd = 8'h1E;
		check_all();
	endtask

	task automatic test_plus3();
		logic [7:0] d;
		reset_dut(MEM_PLUS3);
		for (int s = 0; s < 4; s++) begin
			d = 8'($random(seed));
			d[0] = 1'b1; // Special mode
			d[2:1] = 2'(s);
			port_write(addr_1ffd(), d);
			m_1ffd = d;
			check_all();
		end
		port_write(16'h1FFD, 8'h0C); // Normal map, ROM bit and motor set
		m_1ffd = 8'h0C;
		check_all();
		port_write(16'h3FFD, 8'h17); // A14 low, no decode on +3
		check_all();
		port_write(16'h7FFD, 8'h13);
		m_7ffd = 8'h13;
		check_all();
	endtask

	task automatic test_p1024_profi();
		logic [7:0] d;
		reset_dut(MEM_P1024);
		for (int i = 0; i < 3; i++) begin
			d = 8'($random(seed));
			d[5] = (i == 0); // Bit 5 must not lock yet
			port_write(addr_7ffd(), d);
			m_7ffd = d;
			m_ext = {d[5], d[7], d[6]};
			check_all();
		end
		port_write(16'hEFF7, 8'h04);
		check_all();
		d = 8'($random(seed));
		d[5] = 1'b1;
		port_write(addr_7ffd(), d);
		m_7ffd = d; // Extension frozen
		check_all();
		port_write(addr_7ffd(), 8'($random(seed)));
		check_all();

		reset_dut(MEM_PROFI);
		d = 8'($random(seed));
		port_write(16'hDFFD, d);
		m_ext = d[2:0];
		check_all();
		d = 8'($random(seed));
		d[5] = 1'b0;
		port_write(addr_7ffd(), d);
		m_7ffd = d;
		check_all();
	endtask

	task automatic test_ula_48k();
		logic [15:0] a;
		logic [7:0]  d;
		reset_dut(MEM_128K);
		repeat (4) begin
			a = 16'($random(seed));
			a[0] = 1'b0; // Any even port
			d = 8'($random(seed));
			port_write(a, d);
			m_border = d[2:0];
			m_ear = d[4];
			m_mic = d[3];
			check_all();
		end
		reset_dut(MEM_48K);
		check_val("rom_page_o", rom_page, 4'd15);
		port_write(addr_7ffd(), 8'h17);
		check_all();
	endtask

	initial begin
		reset = 1'b1;
		io_wr = 1'b0;
		addr = '0;
		data = '0;
		mem_wr = 1'b0;
		mode_cfg = MEM_128K;
		test_reset_128k();
		test_7ffd_lock();
		test_plus3();
		test_p1024_profi();
		test_ula_48k();
		$display("TESTS PASSED");
		$finish;
	end

	// Bound assertions end the run at their first failure
	initial begin
		wait (u_dut.u_sva.fail_count != 0);
		$display("A bound assertion on the pager outputs failed");
		$display("TESTS FAILED");
		$fatal(1, "Assertion failure");
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("TESTS FAILED");
		$fatal(1, "Timeout");
	end

endmodule

// File: tb_zx_pager_sva.sv
// Concurrent checks bound to the pager top level
// Special mode is rebuilt from the internal mode and 1FFD register

`timescale 1ns/1ps

module tb_zx_pager_sva
	import zx_pkg::*;
(
	input logic              clk_sys,
	input logic              reset,
	input logic              io_wr_i,
	input logic [ADDR_W-1:0] addr_i,
	input mem_mode_e         mem_mode_i,
	input logic [DATA_W-1:0] reg_1ffd_i,
	input logic              ram_we_i,
	input logic [3:0]        rom_page_i,
	input logic [2:0]        border_i,
	input logic              ear_i,
	input logic              mic_i,
	input logic              scr_page_i,
	input logic              motor_i
);

	logic        special;
	int unsigned fail_count = 0;

	assign special = (mem_mode_i == MEM_PLUS3) & reg_1ffd_i[0];

	// ROM quarter stays read-only outside special mode
	assert property (@(posedge clk_sys) disable iff (reset)
		(addr_i[15:14] == 2'b00 && !special) |-> !ram_we_i)
		else begin
			fail_count++;
			$error("ram_we_o high in the ROM quarter");
		end

	assert property (@(posedge clk_sys) $fell(reset) |-> (!ear_i && !mic_i && !motor_i))
		else begin
			fail_count++;
			$error("ear_o, mic_o or motor_o not low after reset");
		end

	// Held strobe, single write
	assert property (@(posedge clk_sys) disable iff (reset)
		(io_wr_i && $past(io_wr_i) && $past(io_wr_i, 2))
		|=> $stable({rom_page_i, border_i, ear_i, mic_i, scr_page_i, motor_i}))
		else begin
			fail_count++;
			$error("Outputs changed while the write strobe stayed high");
		end

endmodule

bind zx_pager_top tb_zx_pager_sva u_sva (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.io_wr_i    (io_wr_i),
	.addr_i     (addr_i),
	.mem_mode_i (mem_mode),
	.reg_1ffd_i (reg_1ffd),
	.ram_we_i   (ram_we_o),
	.rom_page_i (rom_page_o),
	.border_i   (border_o),
	.ear_i      (ear_o),
	.mic_i      (mic_o),
	.scr_page_i (scr_page_o),
	.motor_i    (motor_o)
);

// File: zx_mem_map.sv
// CPU address to RAM address map, purely combinational
// Bank field sits at bits 20..14, bits 23..21 are always zero
// ROM quarter maps to ROM_REGION plus the 4-bit ROM page
// +3 special mode replaces all four quarters with RAM

`timescale 1ns/1ps

module zx_mem_map
	import zx_pkg::*;
(
	input  logic [ADDR_W-1:0]     addr_i,
	input  logic                  mem_wr_i,
	input  mem_mode_e             mem_mode_i,
	input  logic [DATA_W-1:0]     reg_7ffd_i,
	input  logic [DATA_W-1:0]     reg_1ffd_i,
	input  logic [2:0]            page_ext_i,
	output logic [RAM_ADDR_W-1:0] ram_addr_o,
	output logic                  ram_we_o,
	output logic [3:0]            rom_page_o
);

	logic              plus3;
	logic              zx48;
	logic              special;
	logic [1:0]        quarter; // Which 16 KB slot of the CPU space
	logic [1:0]        spec_set;
	logic              spec_hi;
	logic [2:0]        spec_bank;
	logic [BANK_W-1:0] bank;

	assign plus3    = (mem_mode_i == MEM_PLUS3);
	assign zx48     = (mem_mode_i == MEM_48K);
	assign special  = plus3 & reg_1ffd_i[0];
	assign quarter  = addr_i[ADDR_W-1 -: 2];
	assign spec_set = reg_1ffd_i[2:1];
	assign spec_hi  = |spec_set; // Sets 1..3 start at bank 4

	// ====================
	// ROM page select
	// ====================
	always_comb begin
		if (plus3) begin
			rom_page_o = {2'b10, reg_1ffd_i[2], reg_7ffd_i[4]}; // Pages 8..11
		end else begin
			rom_page_o = {zx48, 2'b11, zx48 | reg_7ffd_i[4]};
		end
	end

	// Special mode sets: 0123, 4567, 4563, 4763
	always_comb begin
		case (quarter)
			2'd0:    spec_bank = spec_hi ? 3'd4 : 3'd0;
			2'd1:    spec_bank = (spec_set == 2'd3) ? 3'd7 : (spec_hi ? 3'd5 : 3'd1);
			2'd2:    spec_bank = spec_hi ? 3'd6 : 3'd2;
			default: spec_bank = (spec_set == 2'd1) ? 3'd7 : 3'd3;
		endcase
	end

	always_comb begin
		if (special) begin
			bank = {{(BANK_W-3){1'b0}}, spec_bank};
		end else begin
			case (quarter)
				2'd0:    bank = {ROM_REGION, rom_page_o};
				2'd1:    bank = BANK_SCREEN;
				2'd2:    bank = BANK_MID;
				default: bank = {1'b0, page_ext_i, reg_7ffd_i[2:0]}; // Switchable top slot
			endcase
		end
	end

	assign ram_addr_o = {{(RAM_ADDR_W-BANK_W-OFFSET_W){1'b0}}, bank, addr_i[OFFSET_W-1:0]};

	// ROM stays read-only unless special mode put RAM there
	assign ram_we_o = mem_wr_i & (special | addr_i[15] | addr_i[14]);

endmodule

// File: zx_pager_top.sv
// Memory pager for a ZX Spectrum host board
// Port writes reach the outputs two clock edges after the strobe is seen high
// RAM address, write enable and ROM page follow the CPU bus with no latency
// Memory mode changes only through reset

`timescale 1ns/1ps

module zx_pager_top
	import zx_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_wr_i,
	input  logic [ADDR_W-1:0]     addr_i,
	input  logic [DATA_W-1:0]     data_i,
	input  logic                  mem_wr_i,
	input  mem_mode_e             mode_cfg_i,
	output logic [RAM_ADDR_W-1:0] ram_addr_o,
	output logic                  ram_we_o,
	output logic [3:0]            rom_page_o,
	output logic [2:0]            border_o,
	output logic                  ear_o,
	output logic                  mic_o,
	output logic                  scr_page_o,
	output logic                  motor_o
);

	logic              port_wr;
	port_e             port_sel;
	logic [DATA_W-1:0] port_data;
	mem_mode_e         mem_mode;
	logic [DATA_W-1:0] reg_7ffd;
	logic [DATA_W-1:0] reg_1ffd;
	logic [2:0]        page_ext;

	// ====================
	// Port write path
	// ====================
	zx_port_decode u_decode (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_wr_i     (io_wr_i),
		.addr_i      (addr_i),
		.data_i      (data_i),
		.mem_mode_i  (mem_mode),
		.port_wr_o   (port_wr),
		.port_sel_o  (port_sel),
		.port_data_o (port_data),
		.port_addr_o () // Registers need only the decoded port
	);

	zx_paging_regs u_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mode_cfg_i  (mode_cfg_i),
		.port_wr_i   (port_wr),
		.port_sel_i  (port_sel),
		.port_data_i (port_data),
		.mem_mode_o  (mem_mode),
		.reg_7ffd_o  (reg_7ffd),
		.reg_1ffd_o  (reg_1ffd),
		.page_ext_o  (page_ext),
		.border_o    (border_o),
		.ear_o       (ear_o),
		.mic_o       (mic_o),
		.scr_page_o  (scr_page_o),
		.motor_o     (motor_o)
	);

	// Memory side
	zx_mem_map u_map (
		.addr_i      (addr_i),
		.mem_wr_i    (mem_wr_i),
		.mem_mode_i  (mem_mode),
		.reg_7ffd_i  (reg_7ffd),
		.reg_1ffd_i  (reg_1ffd),
		.page_ext_i  (page_ext),
		.ram_addr_o  (ram_addr_o),
		.ram_we_o    (ram_we_o),
		.rom_page_o  (rom_page_o)
	);

endmodule

// File: zx_paging_regs.sv
// Paging registers 7FFD, 1FFD, EFF7 and DFFD plus the ULA port latch
// Memory mode is taken from mode_cfg_i only while reset is high
// Lock set by 7FFD bit 5 blocks 7FFD and 1FFD, never EFF7, DFFD or ULA
// In 48K mode the lock is always on

`timescale 1ns/1ps

module zx_paging_regs
	import zx_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  mem_mode_e         mode_cfg_i,
	input  logic              port_wr_i,
	input  port_e             port_sel_i,
	input  logic [DATA_W-1:0] port_data_i,
	output mem_mode_e         mem_mode_o,
	output logic [DATA_W-1:0] reg_7ffd_o,
	output logic [DATA_W-1:0] reg_1ffd_o,
	output logic [2:0]        page_ext_o,
	output logic [2:0]        border_o,
	output logic              ear_o,
	output logic              mic_o,
	output logic              scr_page_o,
	output logic              motor_o
);

	logic zx48;
	logic p1024;
	logic eff7_lock_en; // EFF7 bit 2, also freezes the 1024K extension
	logic page_lock;

	assign zx48  = (mem_mode_o == MEM_48K);
	assign p1024 = (mem_mode_o == MEM_P1024);

	// Pentagon 1024 ignores the 7FFD lock bit until EFF7 bit 2 enables it
	assign page_lock = zx48
		| (~p1024 & reg_7ffd_o[5])
		| (p1024 & eff7_lock_en & reg_7ffd_o[5]);

	// ====================
	// Memory mode latch
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_mode_o <= mode_cfg_i;
		end
	end

	// ====================
	// Paging registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd_o   <= '0;
			reg_1ffd_o   <= '0;
			page_ext_o   <= '0;
			eff7_lock_en <= 1'b0;
		end else if (port_wr_i) begin
			case (port_sel_i)
				PORT_7FFD: begin
					if (!page_lock) begin
						reg_7ffd_o <= port_data_i;
						// Extra bank bits come from the top of the byte
						if (p1024 && !eff7_lock_en) begin
							page_ext_o <= {port_data_i[5], port_data_i[7], port_data_i[6]};
						end
					end
				end
				PORT_1FFD: begin
					if (!page_lock) begin
						reg_1ffd_o <= port_data_i;
					end
				end
				PORT_EFF7: eff7_lock_en <= port_data_i[2];
				PORT_DFFD: page_ext_o <= port_data_i[2:0]; // Profi sets it directly
				default: ;
			endcase
		end
	end

	// ====================
	// ULA port
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_o <= '0;
			ear_o    <= 1'b0;
			mic_o    <= 1'b0;
		end else if (port_wr_i && port_sel_i == PORT_ULA) begin
			border_o <= port_data_i[2:0];
			ear_o    <= port_data_i[4];
			mic_o    <= port_data_i[3];
		end
	end

	assign scr_page_o = reg_7ffd_o[3]; // Shadow screen in bank 7
	assign motor_o    = reg_1ffd_o[3]; // +3 disk motor

endmodule

// File: zx_pkg.sv
// Shared widths, fixed bank numbers and enums for the Spectrum memory pager
// RAM address space is 24 bits, organised as 16 KB banks
// ROM pages sit above RAM under a fixed 3-bit region prefix
// mem_mode_e encodings follow the board's memory-mode selector

package zx_pkg;

	// ====================
	// Bus widths
	// ====================
	localparam int ADDR_W     = 16; // Z80 address bus
	localparam int DATA_W     = 8;  // Z80 data bus
	localparam int RAM_ADDR_W = 24;
	localparam int OFFSET_W   = 14; // Offset inside a 16 KB page
	localparam int BANK_W     = 7;  // Bank field above the offset

	// ====================
	// Fixed pages
	// ====================
	localparam logic [2:0]        ROM_REGION  = 3'b101; // ROM pages above RAM
	localparam logic [BANK_W-1:0] BANK_SCREEN = 7'd5;   // Always at 4000 in normal mode
	localparam logic [BANK_W-1:0] BANK_MID    = 7'd2;   // Always at 8000 in normal mode

	// Machine memory mode, sampled at reset
	typedef enum logic [2:0] {
		MEM_128K  = 3'd0,
		MEM_P1024 = 3'd1,
		MEM_PROFI = 3'd2,
		MEM_48K   = 3'd3,
		MEM_PLUS3 = 3'd4
	} mem_mode_e;

	// Decoded I/O port of a write cycle
	typedef enum logic [2:0] {
		PORT_NONE,
		PORT_7FFD, // 128K paging
		PORT_1FFD, // +3 paging
		PORT_EFF7, // Pentagon 1024 config
		PORT_DFFD, // Profi extension
		PORT_ULA   // Border, EAR, MIC
	} port_e;

endpackage

// File: zx_port_decode.sv
// I/O write decoder for the paging and ULA ports
// io_wr_i must already be qualified with IORQ, WR and not M1
// One write per strobe, taken on the first cycle the strobe is seen high
// Result is registered, so the pulse comes one edge after the strobe edge

`timescale 1ns/1ps

module zx_port_decode
	import zx_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              io_wr_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] data_i,
	input  mem_mode_e         mem_mode_i,
	output logic              port_wr_o,
	output port_e             port_sel_o,
	output logic [DATA_W-1:0] port_data_o,
	output logic [ADDR_W-1:0] port_addr_o
);

	logic  io_wr_q;
	logic  io_wr_rise;
	port_e port_sel;

	assign io_wr_rise = io_wr_i & ~io_wr_q;

	// Partial decode as on the real machines
	always_comb begin
		port_sel = PORT_NONE;
		if (!addr_i[0]) begin
			port_sel = PORT_ULA; // Any even port
		end else if (mem_mode_i == MEM_PROFI && addr_i == 16'hDFFD) begin
			port_sel = PORT_DFFD; // Full decode on Profi
		end else if (mem_mode_i == MEM_P1024 && (&addr_i[15:13]) && !addr_i[12] && !addr_i[3]) begin
			port_sel = PORT_EFF7;
		end else if (mem_mode_i == MEM_PLUS3 && addr_i[15:12] == 4'b0001 && !addr_i[1]) begin
			port_sel = PORT_1FFD;
		end else if (!addr_i[15] && !addr_i[1] && (addr_i[14] || mem_mode_i != MEM_PLUS3)) begin
			port_sel = PORT_7FFD; // +3 also needs A14 high
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q    <= 1'b0;
			port_wr_o  <= 1'b0;
			port_sel_o <= PORT_NONE;
		end else begin
			io_wr_q    <= io_wr_i;
			port_wr_o  <= io_wr_rise & (port_sel != PORT_NONE);
			port_sel_o <= port_sel;
		end
	end

	// Payload copy for the register stage
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			port_data_o <= data_i;
			port_addr_o <= addr_i;
		end
	end

endmodule
